//--- led_pkg.sv
package led_pkg;

	// bus and buffer sizes
	localparam int addr_w   = 12;
	localparam int data_w   = 32;
	localparam int max_leds = 64;   // frame buffer depth
	localparam int idx_w    = 6;
	localparam int len_w    = 7;    // holds 1 to 64
	localparam int cnt_w    = 12;   // pulse and latch counters

	// register map
	localparam logic [addr_w-1:0] reg_ctrl   = 12'h000; // bit 0 start, bit 1 repeat
	localparam logic [addr_w-1:0] reg_len    = 12'h004; // strip length, 1 to 64
	localparam logic [addr_w-1:0] reg_status = 12'h008; // bit 0 busy, 23:8 frame count
	localparam logic [addr_w-1:0] pix_base   = 12'h100; // pixel i at base + 4*i

	// pulse timing in cycles of a 50 MHz clock
	localparam int t1h     = 40;    // 800 ns
	localparam int t1l     = 20;
	localparam int t0h     = 20;
	localparam int t0l     = 40;
	localparam int t_latch = 2600;  // 52 us low latches the strip

	// frame loop states
	localparam logic [2:0] s_idle  = 3'd0;
	localparam logic [2:0] s_fetch = 3'd1; // buffer read in flight
	localparam logic [2:0] s_offer = 3'd2; // word on pix_data, waiting for ready
	localparam logic [2:0] s_drain = 3'd3; // last word taken, wait for tx_idle
	localparam logic [2:0] s_latch = 3'd4;

	// one pixel, either as color channels or as the raw serial word
	typedef union packed {
		struct packed {
			logic [7:0] g;  // wire order, green first
			logic [7:0] r;
			logic [7:0] b;
		} chan;
		logic [23:0] bits;  // shifted out msb first
	} pixel_u;

endpackage

//--- led_pixel_ram.sv
`timescale 1ns/1ps

module led_pixel_ram (
	input  logic                      clk,
	input  logic                      host_we,
	input  logic [led_pkg::idx_w-1:0] host_addr,
	input  led_pkg::pixel_u           host_wdata,
	output led_pkg::pixel_u           host_rdata,
	input  logic                      seq_rd,
	input  logic [led_pkg::idx_w-1:0] seq_addr,
	output led_pkg::pixel_u           seq_rdata
);
	import led_pkg::*;

	pixel_u mem [max_leds];

	// software port, read returns old data on a write cycle
	always_ff @(posedge clk) begin
		if (host_we) begin
			mem[host_addr] <= host_wdata;
		end
		host_rdata <= mem[host_addr];
	end

	// sequencer port holds its word until the next read
	always_ff @(posedge clk) begin
		if (seq_rd) begin
			seq_rdata <= mem[seq_addr];
		end
	end

endmodule

//--- led_apb_regs.sv
`timescale 1ns/1ps

module led_apb_regs (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [led_pkg::addr_w-1:0] paddr,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [led_pkg::data_w-1:0] pwdata,
	output logic [led_pkg::data_w-1:0] prdata,
	output logic                       pready,
	output logic                       pslverr,
	output logic                       host_we,
	output logic [led_pkg::idx_w-1:0]  host_addr,
	output led_pkg::pixel_u            host_wdata,
	input  led_pkg::pixel_u            host_rdata,
	output logic                       start,
	output logic                       repeat_en,
	output logic [led_pkg::len_w-1:0]  strip_len,
	input  logic                       busy,
	input  logic                       frame_done
);
	import led_pkg::*;

	logic              access;
	logic              sel_ctrl;
	logic              sel_len;
	logic              sel_status;
	logic              sel_pix;     // at or above the pixel window
	logic              pix_ok;      // inside the window, index below 64
	logic [addr_w-1:0] pix_off;
	logic              pix_rd;
	logic              len_bad;
	logic              err;
	logic              rd_wait;     // wait cycle of a pixel read done
	logic              wr_en;
	logic [15:0]       frame_cnt;

	assign access     = psel & penable;
	assign sel_ctrl   = (paddr == reg_ctrl);
	assign sel_len    = (paddr == reg_len);
	assign sel_status = (paddr == reg_status);
	assign sel_pix    = (paddr >= pix_base);
	assign pix_off    = paddr - pix_base;
	assign pix_ok     = sel_pix && (pix_off[addr_w-1:idx_w+2] == '0);
	assign host_addr  = pix_off[idx_w+1:2];
	assign pix_rd     = pix_ok && !pwrite;
	assign len_bad    = (pwdata == '0) || (pwdata > data_w'(max_leds));

	assign err = !(sel_ctrl || sel_len || sel_status || pix_ok)
		|| (pwrite && sel_status)
		|| (pwrite && sel_len && len_bad);

	assign pready  = access && !(pix_rd && !rd_wait);  // one wait on pixel reads
	assign pslverr = pready && err;
	assign wr_en   = access && pwrite && !err;
	assign host_we = wr_en && pix_ok;

	// software layout 0x00RRGGBB into wire order
	always_comb begin
		host_wdata.chan.g = pwdata[15:8];
		host_wdata.chan.r = pwdata[23:16];
		host_wdata.chan.b = pwdata[7:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_wait <= 1'b0;
		end else begin
			rd_wait <= access && pix_rd && !rd_wait;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start     <= 1'b0;
			repeat_en <= 1'b0;
			strip_len <= len_w'(1);
			frame_cnt <= '0;
		end else begin
			start <= wr_en && sel_ctrl && pwdata[0]; // single cycle pulse
			if (wr_en && sel_ctrl) begin
				repeat_en <= pwdata[1];
			end
			if (wr_en && sel_len) begin
				strip_len <= pwdata[len_w-1:0];
			end
			if (frame_done) begin
				frame_cnt <= frame_cnt + 16'd1;
			end
		end
	end

	always_comb begin
		prdata = '0;
		if (pix_ok) begin
			prdata[23:16] = host_rdata.chan.r;
			prdata[15:8]  = host_rdata.chan.g;
			prdata[7:0]   = host_rdata.chan.b;
		end else if (sel_ctrl) begin
			prdata[1] = repeat_en; // start bit reads as zero
		end else if (sel_len) begin
			prdata[len_w-1:0] = strip_len;
		end else if (sel_status) begin
			prdata[0]    = busy;
			prdata[23:8] = frame_cnt;
		end
	end

endmodule

//--- led_frame_seq.sv
`timescale 1ns/1ps

module led_frame_seq (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      start,
	input  logic                      repeat_en,
	input  logic [led_pkg::len_w-1:0] strip_len,
	output logic                      busy,
	output logic                      frame_done,
	output logic                      seq_rd,
	output logic [led_pkg::idx_w-1:0] seq_addr,
	input  led_pkg::pixel_u           seq_rdata,
	output logic                      pix_valid,
	output led_pkg::pixel_u           pix_data,
	input  logic                      pix_ready,
	input  logic                      tx_idle
);
	import led_pkg::*;

	logic [2:0]       state;
	logic [idx_w-1:0] idx;        // pixel being fetched or offered
	logic [cnt_w-1:0] latch_cnt;
	logic             last_pix;

	assign last_pix  = ({1'b0, idx} == strip_len - 1'b1);
	assign busy      = (state != s_idle);
	assign seq_rd    = (state == s_fetch);
	assign seq_addr  = idx;
	assign pix_valid = (state == s_offer);
	assign pix_data  = seq_rdata;  // held by the buffer until the next read

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= s_idle;
			idx        <= '0;
			latch_cnt  <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				s_idle: begin
					if (start) begin  // start while busy never reaches here
						idx   <= '0;
						state <= s_fetch;
					end
				end
				s_fetch: begin
					state <= s_offer;
				end
				s_offer: begin
					if (pix_ready) begin
						if (last_pix) begin
							state <= s_drain;
						end else begin
							idx   <= idx + 1'b1;
							state <= s_fetch;
						end
					end
				end
				s_drain: begin
					if (tx_idle) begin  // last bit fully out
						latch_cnt <= '0;
						state     <= s_latch;
					end
				end
				s_latch: begin
					if (latch_cnt == cnt_w'(t_latch - 1)) begin
						frame_done <= 1'b1;
						idx        <= '0;
						state      <= repeat_en ? s_fetch : s_idle;
					end else begin
						latch_cnt <= latch_cnt + 1'b1;
					end
				end
				default: begin
					state <= s_idle;
				end
			endcase
		end
	end

endmodule

//--- ws2812_bit_tx.sv
`timescale 1ns/1ps

module ws2812_bit_tx (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            pix_valid,
	input  led_pkg::pixel_u pix_data,
	output logic            pix_ready,
	output logic            tx_idle,
	output logic            dout
);
	import led_pkg::*;

	pixel_u           shift_q;     // word on the line
	pixel_u           spare_q;     // next word, taken while shifting
	logic             spare_full;
	logic             active;
	logic [4:0]       bit_cnt;
	logic [cnt_w-1:0] pulse_cnt;
	logic             phase_hi;
	logic             cur_bit;
	logic [cnt_w-1:0] hi_last;
	logic [cnt_w-1:0] lo_last;
	logic             take;
	logic             hi_end;
	logic             bit_end;     // last low cycle of a bit
	logic             word_end;
	logic             load_new;    // incoming word straight to the shifter
	logic             load_spare;
	logic             fill_spare;

	assign cur_bit   = shift_q.bits[23];
	assign hi_last   = cur_bit ? cnt_w'(t1h - 1) : cnt_w'(t0h - 1);
	assign lo_last   = cur_bit ? cnt_w'(t1l - 1) : cnt_w'(t0l - 1);
	assign pix_ready = !spare_full;
	assign tx_idle   = !active && !spare_full;
	assign take      = pix_valid && pix_ready;

	assign hi_end     = active && phase_hi && (pulse_cnt == hi_last);
	assign bit_end    = active && !phase_hi && (pulse_cnt == lo_last);
	assign word_end   = bit_end && (bit_cnt == 5'd23);
	assign load_spare = word_end && spare_full;
	assign load_new   = take && (!active || word_end);
	assign fill_spare = take && active && !word_end;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active     <= 1'b0;
			spare_full <= 1'b0;
			bit_cnt    <= '0;
			pulse_cnt  <= '0;
			phase_hi   <= 1'b0;
			dout       <= 1'b0;
		end else begin
			if (load_new || load_spare) begin  // first bit, no gap
				active    <= 1'b1;
				bit_cnt   <= '0;
				pulse_cnt <= '0;
				phase_hi  <= 1'b1;
				dout      <= 1'b1;
			end else if (word_end) begin
				active    <= 1'b0;
				pulse_cnt <= '0;
				dout      <= 1'b0;
			end else if (bit_end) begin
				bit_cnt   <= bit_cnt + 5'd1;
				pulse_cnt <= '0;
				phase_hi  <= 1'b1;
				dout      <= 1'b1;
			end else if (hi_end) begin
				phase_hi  <= 1'b0;
				pulse_cnt <= '0;
				dout      <= 1'b0;
			end else if (active) begin
				pulse_cnt <= pulse_cnt + 1'b1;
			end
			if (load_spare) begin
				spare_full <= 1'b0;
			end else if (fill_spare) begin
				spare_full <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_new) begin
			shift_q <= pix_data;
		end else if (load_spare) begin
			shift_q <= spare_q;
		end else if (bit_end) begin
			shift_q.bits <= {shift_q.bits[22:0], 1'b0};  // next bit to msb
		end
		if (fill_spare) begin
			spare_q <= pix_data;
		end
	end

endmodule

//--- led_strip_top.sv
`timescale 1ns/1ps

module led_strip_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [led_pkg::addr_w-1:0] paddr,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [led_pkg::data_w-1:0] pwdata,
	output logic [led_pkg::data_w-1:0] prdata,
	output logic                       pready,
	output logic                       pslverr,
	output logic                       dout
);
	import led_pkg::*;

	logic             host_we;
	logic [idx_w-1:0] host_addr;
	pixel_u           host_wdata;
	pixel_u           host_rdata;
	logic             start;
	logic             repeat_en;
	logic [len_w-1:0] strip_len;
	logic             busy;
	logic             frame_done;
	logic             seq_rd;
	logic [idx_w-1:0] seq_addr;
	pixel_u           seq_rdata;
	logic             pix_valid;
	pixel_u           pix_data;
	logic             pix_ready;
	logic             tx_idle;

	led_apb_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
		.host_rdata(host_rdata), .start(start), .repeat_en(repeat_en),
		.strip_len(strip_len), .busy(busy), .frame_done(frame_done)
	);

	led_pixel_ram u_ram (
		.clk(clk), .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
		.host_rdata(host_rdata), .seq_rd(seq_rd), .seq_addr(seq_addr),
		.seq_rdata(seq_rdata)
	);

	led_frame_seq u_seq (
		.clk(clk), .rst_n(rst_n), .start(start), .repeat_en(repeat_en),
		.strip_len(strip_len), .busy(busy), .frame_done(frame_done),
		.seq_rd(seq_rd), .seq_addr(seq_addr), .seq_rdata(seq_rdata),
		.pix_valid(pix_valid), .pix_data(pix_data), .pix_ready(pix_ready),
		.tx_idle(tx_idle)
	);

	ws2812_bit_tx u_tx (
		.clk(clk), .rst_n(rst_n), .pix_valid(pix_valid), .pix_data(pix_data),
		.pix_ready(pix_ready), .tx_idle(tx_idle), .dout(dout)
	);

endmodule

//--- tb_ws2812_rx.sv
`timescale 1ns/1ps

module tb_ws2812_rx (
	input  logic        clk,
	input  logic        din,
	output logic [23:0] word,
	output logic        word_stb,   // one cycle per decoded pixel
	output logic        frame_stb,  // first rising edge of a frame
	output int          gap         // low cycles before that frame
);
	localparam int one_min   = 30;   // longer high pulse is a one
	localparam int frame_gap = 100;  // longer than any bit low time

	logic        prev;
	int          hi_cnt;
	int          lo_cnt;
	int          bit_cnt;
	logic [23:0] sr;

	initial begin
		prev      = 1'b0;
		hi_cnt    = 0;
		lo_cnt    = 0;
		bit_cnt   = 0;
		sr        = '0;
		word      = '0;
		word_stb  = 1'b0;
		frame_stb = 1'b0;
		gap       = 0;
	end

	// sampled half a cycle away from the edge that moves dout
	always @(negedge clk) begin
		word_stb  <= 1'b0;
		frame_stb <= 1'b0;
		if (din === 1'b1) begin
			if (!prev) begin
				if (lo_cnt > frame_gap) begin  // long low, new frame
					gap       <= lo_cnt;
					frame_stb <= 1'b1;
					bit_cnt   = 0;
				end
				hi_cnt = 0;
			end
			hi_cnt = hi_cnt + 1;
			prev   = 1'b1;
		end else begin
			if (prev) begin  // falling edge ends the high pulse
				sr      = {sr[22:0], hi_cnt > one_min};
				bit_cnt = bit_cnt + 1;
				if (bit_cnt == 24) begin
					word     <= sr;
					word_stb <= 1'b1;
					bit_cnt  = 0;
				end
				lo_cnt = 0;
			end
			lo_cnt = lo_cnt + 1;
			prev   = 1'b0;
		end
	end

endmodule

//--- tb_led_strip.sv
`timescale 1ns/1ps

module tb_led_strip;
	import led_pkg::*;

	localparam int     seed        = 76;
	localparam int     n_updates   = 24;  // random pixel rewrites
	localparam int     n_frames    = 8;   // upper bound over the whole run
	localparam longint limit_ns    = 2 * n_frames * (max_leds * 24 * 60 + t_latch) * 8;
	localparam int     apb_timeout = 16;

	logic              clk;
	logic              rst_n;
	logic [addr_w-1:0] paddr;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [data_w-1:0] pwdata;
	logic [data_w-1:0] prdata;
	logic              pready;
	logic              pslverr;
	logic              dout;
	logic [23:0]       rx_word;
	logic              rx_word_stb;
	logic              rx_frame_stb;
	int                rx_gap;

	logic [23:0]       model_pix [max_leds];  // 0xRRGGBB as software sees it
	int                model_frames;
	logic [23:0]       got [$];
	int                gaps [$];
	logic [data_w-1:0] rdata;
	logic              err;
	int                len;
	int                idx;
	int                n_seen;

	led_strip_top dut (
		.clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .dout(dout)
	);

	tb_ws2812_rx rx (
		.clk(clk), .din(dout), .word(rx_word), .word_stb(rx_word_stb),
		.frame_stb(rx_frame_stb), .gap(rx_gap)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (rx_word_stb) begin
			got.push_back(rx_word);
		end
		if (rx_frame_stb) begin
			gaps.push_back(rx_gap);
		end
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			stop_run($sformatf("error %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
		end
	endtask

	function automatic logic [addr_w-1:0] pix_addr(input int i);
		return pix_base + addr_w'(4 * i);
	endfunction

	// green, red, blue as they leave on the wire
	function automatic logic [23:0] wire_order(input logic [23:0] rgb);
		return {rgb[15:8], rgb[23:16], rgb[7:0]};
	endfunction

	task automatic apb_xfer(input logic wr, input logic [addr_w-1:0] addr,
		input logic [data_w-1:0] wdata, output logic [data_w-1:0] rd, output logic slverr);
		int n;
		int waits;  // one on a pixel read below index 64
		n = 0;
		waits = (!wr && addr >= pix_base && addr - pix_base < addr_w'(4 * max_leds)) ? 1 : 0;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		while (pready !== 1'b1) begin
			@(negedge clk);
			#1;
			n++;
			if (n > apb_timeout) begin
				stop_run("apb transfer never saw pready");
			end
		end
		check($sformatf("wait states at 0x%0h", addr), waits, n);
		rd     = prdata;
		slverr = pslverr;
		@(posedge clk);  // access phase ends here
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
		output logic slverr);
		logic [data_w-1:0] rd_dummy;
		apb_xfer(1'b1, addr, wdata, rd_dummy, slverr);
	endtask

	task automatic apb_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] rd,
		output logic slverr);
		apb_xfer(1'b0, addr, '0, rd, slverr);
	endtask

	task automatic wait_idle();
		logic [data_w-1:0] st;
		logic              e;
		apb_read(reg_status, st, e);
		while (st[0]) begin
			apb_read(reg_status, st, e);
		end
	endtask

	task automatic wait_count(input int target);
		logic [data_w-1:0] st;
		logic              e;
		apb_read(reg_status, st, e);
		while (int'(st[23:8]) < target) begin
			apb_read(reg_status, st, e);
		end
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		model_frames = 0;
		void'($urandom(seed));
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		apb_read(reg_len, rdata, err);
		check("length after reset", 1, rdata);
		apb_read(reg_status, rdata, err);
		check("status after reset", 0, rdata);

		// pixel readback
		for (int i = 0; i < max_leds; i++) begin
			model_pix[i] = 24'($urandom);
			apb_write(pix_addr(i), {8'h00, model_pix[i]}, err);
			check("pixel write", 0, err);
		end
		for (int i = 0; i < n_updates; i++) begin
			idx            = $urandom % max_leds;
			model_pix[idx] = 24'($urandom);
			apb_write(pix_addr(idx), {8'h00, model_pix[idx]}, err);
		end
		for (int i = 0; i < max_leds; i++) begin
			apb_read(pix_addr(i), rdata, err);
			check($sformatf("pixel readback %0d", i), {8'h00, model_pix[i]}, rdata);
		end

		// bus errors
		apb_read(12'h00c, rdata, err);
		check("unmapped read", 1, err);
		apb_write(12'h0fc, 32'h1, err);
		check("unmapped write", 1, err);
		apb_read(pix_addr(max_leds), rdata, err);
		check("pixel index 64 read", 1, err);
		apb_write(pix_addr(100), 32'h123456, err);
		check("pixel index 100 write", 1, err);
		apb_write(reg_status, 32'h1, err);
		check("status write", 1, err);
		apb_write(reg_len, 32'd5, err);
		check("length write", 0, err);
		apb_write(reg_len, 32'd0, err);
		check("length 0", 1, err);
		apb_write(reg_len, 32'd65, err);
		check("length 65", 1, err);
		apb_read(reg_len, rdata, err);
		check("length after reject", 5, rdata);

		// single frame
		len = 1 + ($urandom % max_leds);
		apb_write(reg_len, len, err);
		got.delete();
		apb_write(reg_ctrl, 32'h1, err);
		wait_idle();
		check("frame word count", len, got.size());
		for (int i = 0; i < len; i++) begin
			check($sformatf("frame pixel %0d", i), wire_order(model_pix[i]), got[i]);
		end
		model_frames++;
		apb_read(reg_status, rdata, err);
		check("busy after frame", 0, rdata[0]);
		check("frame count", model_frames, rdata[23:8]);

		// repeat mode, latch gap, then stop
		len = 1 + ($urandom % 16);
		for (int i = 0; i < len; i++) begin
			model_pix[i] = 24'($urandom);
			apb_write(pix_addr(i), {8'h00, model_pix[i]}, err);
		end
		apb_write(reg_len, len, err);
		got.delete();
		gaps.delete();
		apb_write(reg_ctrl, 32'h3, err);
		wait_count(model_frames + 3);
		apb_write(reg_ctrl, 32'h0, err);  // fourth frame already under way
		wait_idle();
		model_frames += 4;
		check("repeat word count", 4 * len, got.size());
		for (int i = 0; i < got.size(); i++) begin
			check($sformatf("repeat pixel %0d", i), wire_order(model_pix[i % len]), got[i]);
		end
		check("repeat frame starts", 4, gaps.size());
		for (int i = 1; i < gaps.size(); i++) begin
			check($sformatf("latch gap of %0d cycles", gaps[i]), 1, gaps[i] >= t_latch);
		end
		apb_read(reg_status, rdata, err);
		check("frame count after stop", model_frames, rdata[23:8]);
		n_seen = got.size();
		repeat (2 * t_latch) @(posedge clk);
		check("no words after stop", n_seen, got.size());
		apb_read(reg_status, rdata, err);
		check("frame count settled", model_frames, rdata[23:8]);

		// second start while busy
		len = 1 + ($urandom % max_leds);
		apb_write(reg_len, len, err);
		got.delete();
		apb_write(reg_ctrl, 32'h1, err);
		apb_write(reg_ctrl, 32'h1, err);  // lands mid frame
		wait_idle();
		check("word count with second start", len, got.size());
		model_frames++;
		apb_read(reg_status, rdata, err);
		check("frame count with second start", model_frames, rdata[23:8]);

		$display("No errors");
		$finish;
	end

	initial begin
		#(limit_ns);
		stop_run("watchdog: simulation ran past its time limit");
	end

endmodule

//--- verilog.f
led_pkg.sv
led_pixel_ram.sv
led_apb_regs.sv
led_frame_seq.sv
ws2812_bit_tx.sv
led_strip_top.sv
tb_ws2812_rx.sv
tb_led_strip.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -Mdir obj_dir
TOP       = tb_led_strip
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
